// ==== cache_memory/cache_memory.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_memory
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       data_req_i,
   input  fe_req_t    req_i,
   output data_t      data_rdata_o,
   output logic       data_ack_o,
   output logic       fill_req_o,
   output word_addr_t fill_addr_o,
   input  logic       fill_done_i,
   input  data_t      fill_data_i,
   output logic       wb_empty_o,
   output wr_req_t    wb_head_o,
   input  logic       wb_pop_i,
   input  logic       invalidate_i,
   output logic       read_hit_o,
   output logic       read_miss_o,
   output logic       write_hit_o,
   output logic       write_miss_o
);

   localparam int NLINES = 2**`CACHE_NLINES_W;

   mem_state_e        state_q;
   mem_state_e        state_d;
   tag_t              tag_mem  [NLINES];
   data_t             data_mem [NLINES];
   logic [NLINES-1:0] valid_q;
   index_t            idx;
   tag_t              tag;
   logic              is_write;
   logic              hit;
   logic              wb_full;
   logic              wb_push;
   wr_req_t           wb_data;
   data_t             merged;
   logic              installing;

   assign idx      = req_i.addr[`CACHE_NLINES_W-1:0];
   assign tag      = req_i.addr[`CACHE_ADDR_W-1:`CACHE_NLINES_W];
   assign is_write = |req_i.wstrb;
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);

   // byte merge of a write hit into the stored word
   always_comb begin
      for (int b = 0; b < $bits(strb_t); b++) begin
         merged[8*b +: 8] = req_i.wstrb[b] ? req_i.wdata[8*b +: 8] : data_mem[idx][8*b +: 8];
      end
   end

   // every store goes through, stall while the buffer is full
   assign wb_push      = (state_q == LOOKUP) && is_write && !wb_full;
   assign wb_data.addr = req_i.addr;
   assign wb_data.data = req_i.wdata;
   assign wb_data.strb = req_i.wstrb;
   assign installing   = (state_q == FILL) && fill_done_i;

   assign data_ack_o   = wb_push || ((state_q == LOOKUP) && !is_write && hit)
                         || (state_q == RESPOND);
   assign data_rdata_o = data_mem[idx];
   assign fill_req_o   = (state_q == FILL);
   assign fill_addr_o  = req_i.addr;

   // one event per data request, taken when leaving LOOKUP
   assign read_hit_o   = (state_q == LOOKUP) && !is_write && hit;
   assign read_miss_o  = (state_q == LOOKUP) && !is_write && !hit;
   assign write_hit_o  = wb_push && hit;
   assign write_miss_o = wb_push && !hit;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: if (data_req_i) state_d = LOOKUP;
         LOOKUP: begin
            if (data_ack_o) begin
               state_d = IDLE;
            end else if (!is_write) begin
               state_d = WAIT_EMPTY;
            end
         end
         WAIT_EMPTY: if (wb_empty_o) state_d = FILL;
         FILL:       if (fill_done_i) state_d = RESPOND;
         RESPOND:    state_d = IDLE;
         default:    state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wb_push && hit) begin
         data_mem[idx] <= merged;
      end else if (installing) begin
         data_mem[idx] <= fill_data_i;
         tag_mem[idx]  <= tag;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || invalidate_i) begin
         valid_q <= '0;
      end else if (installing) begin
         valid_q[idx] <= 1'b1;
      end
   end

   cache_write_buffer u_write_buffer (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_i     (wb_push),
      .push_data_i(wb_data),
      .pop_i      (wb_pop_i),
      .head_o     (wb_head_o),
      .full_o     (wb_full),
      .empty_o    (wb_empty_o)
   );

endmodule

`default_nettype wire

// ==== cache_memory/cache_write_buffer.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_write_buffer
   import cache_pkg::*;
#(
   parameter int DEPTH_W = `CACHE_WBUF_DEPTH_W
) (
   input  logic    clk_i,
   input  logic    reset_i,
   input  logic    push_i,
   input  wr_req_t push_data_i,
   input  logic    pop_i,
   output wr_req_t head_o,
   output logic    full_o,
   output logic    empty_o
);

   localparam int DEPTH = 2**DEPTH_W;

   wr_req_t            mem [DEPTH];
   logic [DEPTH_W-1:0] wptr_q;
   logic [DEPTH_W-1:0] rptr_q;
   logic [DEPTH_W:0]   count_q;
   logic               do_push;
   logic               do_pop;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign full_o  = (count_q == (DEPTH_W+1)'(DEPTH));
   assign empty_o = (count_q == '0);
   assign head_o  = mem[rptr_q];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wptr_q] <= push_data_i;
      end
   end

   // pointers wrap naturally at the power-of-two depth
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         count_q <= '0;
      end else begin
         if (do_push) wptr_q <= wptr_q + 1'b1;
         if (do_pop) rptr_q <= rptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== common/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// word address width, without the ctrl select bit
`define CACHE_ADDR_W 10

// processor and memory side data width
`define CACHE_DATA_W 32

// line index width, 16 direct-mapped lines
`define CACHE_NLINES_W 4

// write-through buffer holds 2**n stores
`define CACHE_WBUF_DEPTH_W 2

// hit and miss counters
`define CACHE_CNT_W 16

// low address bits that pick a control register
`define CACHE_CTRL_ADDR_W 3

`endif

// ==== common/cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0]                 word_addr_t;
   typedef logic [`CACHE_DATA_W-1:0]                 data_t;
   typedef logic [`CACHE_DATA_W/8-1:0]               strb_t;
   typedef logic [`CACHE_NLINES_W-1:0]               index_t;
   typedef logic [`CACHE_ADDR_W-`CACHE_NLINES_W-1:0] tag_t;
   typedef logic [`CACHE_CNT_W-1:0]                  cnt_t;
   typedef logic [`CACHE_CTRL_ADDR_W-1:0]            ctrl_sel_t;

   // registered processor request, ctrl set for control register access
   typedef struct packed {
      logic       ctrl;
      word_addr_t addr;
      data_t      wdata;
      strb_t      wstrb;
   } fe_req_t;

   // one store waiting in the write-through buffer
   typedef struct packed {
      word_addr_t addr;
      data_t      data;
      strb_t      strb;
   } wr_req_t;

   // memory bus request, zero strobes mean a read
   typedef struct packed {
      word_addr_t addr;
      data_t      wdata;
      strb_t      wstrb;
   } be_req_t;

   typedef enum logic [`CACHE_CTRL_ADDR_W-1:0] {
      RD_HIT     = 3'd0,
      RD_MISS    = 3'd1,
      WR_HIT     = 3'd2,
      WR_MISS    = 3'd3,
      STATUS     = 3'd4,
      INVALIDATE = 3'd5
   } ctrl_reg_e;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WAIT_EMPTY,
      FILL,
      RESPOND
   } mem_state_e;

endpackage

`default_nettype wire

// ==== hw/cache_back_end.sv ====
`default_nettype none

module cache_back_end
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       wb_empty_i,
   input  wr_req_t    wb_head_i,
   output logic       wb_pop_o,
   input  logic       fill_req_i,
   input  word_addr_t fill_addr_i,
   output logic       fill_done_o,
   output data_t      fill_data_o,
   output logic       be_avalid_o,
   output be_req_t    be_req_o,
   input  data_t      be_rdata_i,
   input  logic       be_rvalid_i,
   input  logic       be_ready_i
);

   typedef enum logic [1:0] {
      BE_IDLE,
      BE_WRITE,
      BE_READ,
      BE_WAIT
   } be_state_e;

   be_state_e state_q;
   be_state_e state_d;

   // pending stores go first, a fill only once they drained
   always_comb begin
      state_d = state_q;
      case (state_q)
         BE_IDLE: begin
            if (!wb_empty_i) begin
               state_d = BE_WRITE;
            end else if (fill_req_i) begin
               state_d = BE_READ;
            end
         end
         BE_WRITE: if (be_ready_i) state_d = BE_IDLE;
         BE_READ:  if (be_ready_i) state_d = BE_WAIT;
         BE_WAIT:  if (be_rvalid_i) state_d = BE_IDLE;
         default:  state_d = BE_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= BE_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign be_avalid_o = (state_q == BE_WRITE) || (state_q == BE_READ);
   assign wb_pop_o    = (state_q == BE_WRITE) && be_ready_i;
   assign fill_done_o = (state_q == BE_WAIT) && be_rvalid_i;
   assign fill_data_o = be_rdata_i;

   // head stays put until popped, so the request is stable
   always_comb begin
      if (state_q == BE_WRITE) begin
         be_req_o.addr  = wb_head_i.addr;
         be_req_o.wdata = wb_head_i.data;
         be_req_o.wstrb = wb_head_i.strb;
      end else begin
         be_req_o.addr  = fill_addr_i;
         be_req_o.wdata = '0;
         be_req_o.wstrb = '0;
      end
   end

endmodule

`default_nettype wire

// ==== hw/cache_control.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_control
   import cache_pkg::*;
(
   input  logic    clk_i,
   input  logic    reset_i,
   input  logic    ctrl_req_i,
   input  fe_req_t req_i,
   output data_t   ctrl_rdata_o,
   output logic    ctrl_ack_o,
   input  logic    read_hit_i,
   input  logic    read_miss_i,
   input  logic    write_hit_i,
   input  logic    write_miss_i,
   input  logic    wb_empty_i,
   input  logic    invalidate_i,
   output logic    invalidate_o,
   input  logic    wbuf_empty_i,
   output logic    wbuf_empty_o
);

   logic      ack_q;
   logic      own_inv;
   ctrl_sel_t sel;
   cnt_t      rd_hit_q;
   cnt_t      rd_miss_q;
   cnt_t      wr_hit_q;
   cnt_t      wr_miss_q;

   // counters stick at all ones
   function automatic cnt_t sat_inc(cnt_t cnt, logic ev);
      if (ev && (cnt != '1)) begin
         return cnt + 1'b1;
      end
      return cnt;
   endfunction

   assign sel        = req_i.addr[`CACHE_CTRL_ADDR_W-1:0];
   assign ctrl_ack_o = ack_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= ctrl_req_i;
      end
   end

   // one-cycle pulse on a write to INVALIDATE
   assign own_inv      = ack_q && (|req_i.wstrb) && (ctrl_reg_e'(sel) == INVALIDATE);
   assign invalidate_o = own_inv | invalidate_i;
   assign wbuf_empty_o = wb_empty_i & wbuf_empty_i;

   always_ff @(posedge clk_i) begin
      if (reset_i || own_inv) begin
         rd_hit_q  <= '0;
         rd_miss_q <= '0;
         wr_hit_q  <= '0;
         wr_miss_q <= '0;
      end else begin
         rd_hit_q  <= sat_inc(rd_hit_q, read_hit_i);
         rd_miss_q <= sat_inc(rd_miss_q, read_miss_i);
         wr_hit_q  <= sat_inc(wr_hit_q, write_hit_i);
         wr_miss_q <= sat_inc(wr_miss_q, write_miss_i);
      end
   end

   always_comb begin
      ctrl_rdata_o = '0;
      case (ctrl_reg_e'(sel))
         RD_HIT:  ctrl_rdata_o = data_t'(rd_hit_q);
         RD_MISS: ctrl_rdata_o = data_t'(rd_miss_q);
         WR_HIT:  ctrl_rdata_o = data_t'(wr_hit_q);
         WR_MISS: ctrl_rdata_o = data_t'(wr_miss_q);
         STATUS:  ctrl_rdata_o[0] = wbuf_empty_o;
         default: ctrl_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/cache_front_end.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_front_end
   import cache_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  avalid_i,
   input  logic [`CACHE_ADDR_W:0] addr_i,
   input  data_t                 wdata_i,
   input  strb_t                 wstrb_i,
   output data_t                 rdata_o,
   output logic                  rvalid_o,
   output logic                  ready_o,
   output logic                  data_req_o,
   output fe_req_t               req_o,
   input  data_t                 data_rdata_i,
   input  logic                  data_ack_i,
   output logic                  ctrl_req_o,
   input  data_t                 ctrl_rdata_i,
   input  logic                  ctrl_ack_i
);

   fe_req_t req_q;
   logic    req_valid_q;
   logic    capture;
   logic    ack;
   logic    rvalid_q;
   data_t   rdata_q;

   // accept only when nothing is pending
   assign capture    = avalid_i && !req_valid_q;
   // top address bit selects the control registers
   assign data_req_o = capture && !addr_i[`CACHE_ADDR_W];
   assign ctrl_req_o = capture && addr_i[`CACHE_ADDR_W];

   assign ack     = req_valid_q && (req_q.ctrl ? ctrl_ack_i : data_ack_i);
   assign ready_o = ack;
   assign req_o   = req_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         req_valid_q <= 1'b0;
      end else if (capture) begin
         req_valid_q <= 1'b1;
      end else if (ack) begin
         req_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) begin
         req_q.ctrl  <= addr_i[`CACHE_ADDR_W];
         req_q.addr  <= addr_i[`CACHE_ADDR_W-1:0];
         req_q.wdata <= wdata_i;
         req_q.wstrb <= wstrb_i;
      end
   end

   // read data goes out one cycle after ready
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= ack && !(|req_q.wstrb);
      end
   end

   always_ff @(posedge clk_i) begin
      if (ack) begin
         rdata_q <= req_q.ctrl ? ctrl_rdata_i : data_rdata_i;
      end
   end

   assign rvalid_o = rvalid_q;
   assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_top
   import cache_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   // processor side
   input  logic                  avalid_i,
   input  logic [`CACHE_ADDR_W:0] addr_i,
   input  data_t                 wdata_i,
   input  strb_t                 wstrb_i,
   output data_t                 rdata_o,
   output logic                  rvalid_o,
   output logic                  ready_o,
   // memory side
   output logic                  be_avalid_o,
   output be_req_t               be_req_o,
   input  data_t                 be_rdata_i,
   input  logic                  be_rvalid_i,
   input  logic                  be_ready_i,
   // chains between caches
   input  logic                  invalidate_i,
   output logic                  invalidate_o,
   input  logic                  wbuf_empty_i,
   output logic                  wbuf_empty_o
);

   fe_req_t    fe_req;
   logic       data_req;
   logic       data_ack;
   data_t      data_rdata;
   logic       ctrl_req;
   logic       ctrl_ack;
   data_t      ctrl_rdata;
   logic       wb_empty;
   wr_req_t    wb_head;
   logic       wb_pop;
   logic       fill_req;
   word_addr_t fill_addr;
   logic       fill_done;
   data_t      fill_data;
   logic       read_hit;
   logic       read_miss;
   logic       write_hit;
   logic       write_miss;

   cache_front_end u_front_end (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .avalid_i    (avalid_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .rdata_o     (rdata_o),
      .rvalid_o    (rvalid_o),
      .ready_o     (ready_o),
      .data_req_o  (data_req),
      .req_o       (fe_req),
      .data_rdata_i(data_rdata),
      .data_ack_i  (data_ack),
      .ctrl_req_o  (ctrl_req),
      .ctrl_rdata_i(ctrl_rdata),
      .ctrl_ack_i  (ctrl_ack)
   );

   // memory is cleared by the chained invalidate, not only our own
   cache_memory u_memory (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .data_req_i  (data_req),
      .req_i       (fe_req),
      .data_rdata_o(data_rdata),
      .data_ack_o  (data_ack),
      .fill_req_o  (fill_req),
      .fill_addr_o (fill_addr),
      .fill_done_i (fill_done),
      .fill_data_i (fill_data),
      .wb_empty_o  (wb_empty),
      .wb_head_o   (wb_head),
      .wb_pop_i    (wb_pop),
      .invalidate_i(invalidate_o),
      .read_hit_o  (read_hit),
      .read_miss_o (read_miss),
      .write_hit_o (write_hit),
      .write_miss_o(write_miss)
   );

   cache_back_end u_back_end (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wb_empty_i (wb_empty),
      .wb_head_i  (wb_head),
      .wb_pop_o   (wb_pop),
      .fill_req_i (fill_req),
      .fill_addr_i(fill_addr),
      .fill_done_o(fill_done),
      .fill_data_o(fill_data),
      .be_avalid_o(be_avalid_o),
      .be_req_o   (be_req_o),
      .be_rdata_i (be_rdata_i),
      .be_rvalid_i(be_rvalid_i),
      .be_ready_i (be_ready_i)
   );

   cache_control u_control (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .ctrl_req_i  (ctrl_req),
      .req_i       (fe_req),
      .ctrl_rdata_o(ctrl_rdata),
      .ctrl_ack_o  (ctrl_ack),
      .read_hit_i  (read_hit),
      .read_miss_i (read_miss),
      .write_hit_i (write_hit),
      .write_miss_i(write_miss),
      .wb_empty_i  (wb_empty),
      .invalidate_i(invalidate_i),
      .invalidate_o(invalidate_o),
      .wbuf_empty_i(wbuf_empty_i),
      .wbuf_empty_o(wbuf_empty_o)
   );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/cache_pkg.sv
cache_memory/cache_write_buffer.sv
cache_memory/cache_memory.sv
hw/cache_front_end.sv
hw/cache_control.sv
hw/cache_back_end.sv
hw/cache_top.sv
verif/cache_checker.sv
verif/cache_tb.sv

// ==== verif/cache_checker.sv ====
`default_nettype none

module cache_checker
   import cache_pkg::*;
(
   input logic    clk_i,
   input logic    reset_i,
   input logic    top_ready_i,
   input logic    top_rvalid_i,
   input strb_t   cpu_wstrb_i,
   input logic    be_avalid_i,
   input be_req_t be_req_i,
   input logic    be_ready_i,
   input logic    inv_pulse_i
);

   int fail_cnt;

   // a stalled memory request holds still until accepted
   be_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      (be_avalid_i && !be_ready_i) |=> (be_avalid_i && $stable(be_req_i)))
   else begin
      $error("memory request changed while stalled");
      fail_cnt++;
   end

   // read data only right after the ready of a read
   rvalid_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
      top_rvalid_i |-> $past(top_ready_i && (cpu_wstrb_i == '0)))
   else begin
      $error("rvalid without a preceding read ready");
      fail_cnt++;
   end

   read_gets_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
      (top_ready_i && (cpu_wstrb_i == '0)) |=> top_rvalid_i)
   else begin
      $error("read ready not followed by rvalid");
      fail_cnt++;
   end

   // outputs quiet once reset has been seen
   quiet_in_reset: assert property (@(posedge clk_i)
      reset_i |=> !(top_ready_i || top_rvalid_i || be_avalid_i || inv_pulse_i))
   else begin
      $error("output active during reset");
      fail_cnt++;
   end

endmodule

bind cache_top cache_checker u_checker (
   .clk_i       (clk_i),
   .reset_i     (reset_i),
   .top_ready_i (ready_o),
   .top_rvalid_i(rvalid_o),
   .cpu_wstrb_i (wstrb_i),
   .be_avalid_i (be_avalid_o),
   .be_req_i    (be_req_o),
   .be_ready_i  (be_ready_i),
   .inv_pulse_i (invalidate_o)
);

`default_nettype wire

// ==== verif/cache_tb.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_tb
   import cache_pkg::*;
();

   localparam logic [2:0] OP_RD    = 3'd0;
   localparam logic [2:0] OP_WR    = 3'd1;
   localparam logic [2:0] OP_CRD   = 3'd2;
   localparam logic [2:0] OP_CWR   = 3'd3;
   localparam logic [2:0] OP_HOLD  = 3'd4;
   localparam logic [2:0] OP_DRAIN = 3'd5;
   localparam int NWORDS = 2**`CACHE_ADDR_W;
   localparam int NLINES = 2**`CACHE_NLINES_W;

   // one table row, exp is the read value and hit the predicted lookup result
   typedef struct packed {
      logic [2:0]             kind;
      logic [`CACHE_ADDR_W:0] addr;
      data_t                  data;
      strb_t                  strb;
      data_t                  exp;
      logic                   hit;
   } op_row_t;

   logic                   clk_i;
   logic                   reset_i;
   logic                   avalid_i;
   logic [`CACHE_ADDR_W:0] addr_i;
   data_t                  wdata_i;
   strb_t                  wstrb_i;
   data_t                  rdata_o;
   logic                   rvalid_o;
   logic                   ready_o;
   logic                   be_avalid_o;
   be_req_t                be_req_o;
   data_t                  be_rdata_i;
   logic                   be_rvalid_i;
   logic                   be_ready_i;
   logic                   invalidate_i;
   logic                   invalidate_o;
   logic                   wbuf_empty_i;
   logic                   wbuf_empty_o;

   op_row_t ops[$];
   data_t   golden [NWORDS];
   data_t   bus_mem [NWORDS];
   logic    line_valid [NLINES];
   tag_t    line_tag [NLINES];
   int      n_rd_hit;
   int      n_rd_miss;
   int      n_wr_hit;
   int      n_wr_miss;
   int      held_stores;
   logic    holding;
   logic    bus_hold;
   int      bus_reads;
   int      bus_writes;
   int      stores_sent;
   int      inv_pulses;
   int      inv_expected;
   int      cycles;
   int      cycle_limit = 100;

   cache_top u_cache_top (.*);

   always #50 clk_i = ~clk_i;

   function automatic data_t init_word(input int a);
      return (data_t'(a) * 32'h0101_0101) ^ 32'hA5A5_A5A5;
   endfunction

   function automatic data_t apply_strobes(input data_t old, input data_t wdata, input strb_t strb);
      data_t res;
      res = old;
      for (int b = 0; b < $bits(strb_t); b++) begin
         if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [`CACHE_ADDR_W:0] ctrl_addr(input ctrl_reg_e sel);
      return {1'b1, 7'd0, sel};
   endfunction

   task automatic check_value(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // expected values follow the cache rules: no write-allocate, fill on read miss
   task automatic add_op(input logic [2:0] kind, input logic [`CACHE_ADDR_W:0] addr,
                         input data_t data, input strb_t strb);
      op_row_t row;
      index_t  idx;
      tag_t    tag;
      idx = addr[`CACHE_NLINES_W-1:0];
      tag = addr[`CACHE_ADDR_W-1:`CACHE_NLINES_W];
      row.kind = kind;
      row.addr = addr;
      row.data = data;
      row.strb = strb;
      row.exp  = '0;
      row.hit  = line_valid[idx] && (line_tag[idx] == tag);
      case (kind)
         OP_RD: begin
            row.exp = golden[addr[`CACHE_ADDR_W-1:0]];
            if (row.hit) begin
               n_rd_hit++;
            end else begin
               n_rd_miss++;
               line_valid[idx] = 1'b1;
               line_tag[idx]   = tag;
            end
         end
         OP_WR: begin
            golden[addr[`CACHE_ADDR_W-1:0]] =
               apply_strobes(golden[addr[`CACHE_ADDR_W-1:0]], data, strb);
            if (row.hit) n_wr_hit++;
            else n_wr_miss++;
            if (holding) held_stores++;
         end
         OP_CRD: begin
            case (addr[`CACHE_CTRL_ADDR_W-1:0])
               RD_HIT:  row.exp = data_t'(n_rd_hit);
               RD_MISS: row.exp = data_t'(n_rd_miss);
               WR_HIT:  row.exp = data_t'(n_wr_hit);
               WR_MISS: row.exp = data_t'(n_wr_miss);
               STATUS:  row.exp = data_t'(held_stores == 0);
               default: row.exp = '0;
            endcase
         end
         OP_CWR: begin
            if (addr[`CACHE_CTRL_ADDR_W-1:0] == INVALIDATE) begin
               foreach (line_valid[i]) line_valid[i] = 1'b0;
               n_rd_hit  = 0;
               n_rd_miss = 0;
               n_wr_hit  = 0;
               n_wr_miss = 0;
            end
         end
         OP_HOLD: holding = 1'b1;
         default: begin
            holding     = 1'b0;
            held_stores = 0;
         end
      endcase
      ops.push_back(row);
   endtask

   task automatic build_table();
      // cold reads, then repeats that must hit
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_RD, 11'h024, '0, '0);
      add_op(OP_RD, 11'h024, '0, '0);
      // partial stores, hit and miss
      add_op(OP_WR, 11'h013, 32'h1122_3344, 4'b0101);
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_WR, 11'h055, 32'hDEAD_BEEF, 4'b1100);
      add_op(OP_RD, 11'h055, '0, '0);
      add_op(OP_WR, 11'h055, 32'hCAFE_F00D, 4'b0011);
      add_op(OP_RD, 11'h055, '0, '0);
      // same index, different tag
      add_op(OP_RD, 11'h0A3, '0, '0);
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_RD, 11'h0A3, '0, '0);
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_CRD, ctrl_addr(RD_HIT), '0, '0);
      add_op(OP_CRD, ctrl_addr(RD_MISS), '0, '0);
      add_op(OP_CRD, ctrl_addr(WR_HIT), '0, '0);
      add_op(OP_CRD, ctrl_addr(WR_MISS), '0, '0);
      // invalidate clears lines and counters
      add_op(OP_CWR, ctrl_addr(INVALIDATE), 32'h1, 4'hF);
      add_op(OP_CRD, ctrl_addr(RD_HIT), '0, '0);
      add_op(OP_CRD, ctrl_addr(RD_MISS), '0, '0);
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_CRD, ctrl_addr(RD_MISS), '0, '0);
      // stores pile up while the memory bus is stalled
      add_op(OP_DRAIN, '0, '0, '0);
      add_op(OP_HOLD, '0, '0, '0);
      add_op(OP_WR, 11'h100, 32'h0BAD_F00D, 4'hF);
      add_op(OP_WR, 11'h101, 32'h7654_3210, 4'b0011);
      add_op(OP_WR, 11'h013, 32'h9900_0000, 4'b1000);
      add_op(OP_WR, 11'h100, 32'h1357_9BDF, 4'b0110);
      add_op(OP_RD, 11'h013, '0, '0);
      add_op(OP_CRD, ctrl_addr(STATUS), '0, '0);
      add_op(OP_DRAIN, '0, '0, '0);
      add_op(OP_CRD, ctrl_addr(STATUS), '0, '0);
      add_op(OP_RD, 11'h101, '0, '0);
      add_op(OP_RD, 11'h100, '0, '0);
      add_op(OP_CRD, ctrl_addr(WR_HIT), '0, '0);
      add_op(OP_CRD, ctrl_addr(WR_MISS), '0, '0);
      add_op(OP_DRAIN, '0, '0, '0);
   endtask

   // starts and ends on a falling edge
   task automatic run_op(input op_row_t row);
      int reads_before;
      reads_before = bus_reads;
      case (row.kind)
         OP_HOLD: bus_hold = 1'b1;
         OP_DRAIN: begin
            bus_hold = 1'b0;
            // wait until the model took every store sent so far
            while (bus_writes != stores_sent) @(negedge clk_i);
            @(negedge clk_i);
         end
         default: begin
            avalid_i = 1'b1;
            addr_i   = row.addr;
            wdata_i  = row.data;
            wstrb_i  = row.strb;
            @(negedge clk_i);
            while (!ready_o) @(negedge clk_i);
            avalid_i = 1'b0;
            @(negedge clk_i);
            if (row.kind == OP_RD || row.kind == OP_CRD) begin
               check_value(data_t'(rvalid_o), 32'd1, "rvalid after read");
               check_value(rdata_o, row.exp, "read data");
            end
            if (row.kind == OP_RD) begin
               check_value(bus_reads - reads_before, row.hit ? 0 : 1, "memory reads");
            end
            if (row.kind == OP_WR) begin
               stores_sent++;
            end
            if (row.kind == OP_CWR
                && row.addr[`CACHE_CTRL_ADDR_W-1:0] == INVALIDATE) begin
               inv_expected++;
            end
            check_value(inv_pulses, inv_expected, "invalidate pulses");
         end
      endcase
   endtask

   // memory model with random grant and read latency
   initial begin : bus_model
      be_req_t req;
      void'($urandom(95));
      forever begin
         @(negedge clk_i);
         if (!reset_i && be_avalid_o && !bus_hold) begin
            repeat ($urandom_range(3)) @(negedge clk_i);
            req = be_req_o;
            be_ready_i = 1'b1;
            if (req.wstrb != '0) begin
               bus_mem[req.addr] = apply_strobes(bus_mem[req.addr], req.wdata, req.wstrb);
               bus_writes++;
            end else begin
               bus_reads++;
            end
            @(negedge clk_i);
            be_ready_i = 1'b0;
            if (req.wstrb == '0) begin
               repeat ($urandom_range(3)) @(negedge clk_i);
               be_rdata_i  = bus_mem[req.addr];
               be_rvalid_i = 1'b1;
               @(negedge clk_i);
               be_rvalid_i = 1'b0;
            end
         end
      end
   end

   always @(negedge clk_i) begin
      if (!reset_i && invalidate_o) inv_pulses++;
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycles);
         $display("Simulation finished: FAIL");
         $fatal(1, "timeout");
      end
   end

   initial begin
      clk_i        = 1'b0;
      reset_i      = 1'b1;
      avalid_i     = 1'b0;
      addr_i       = '0;
      wdata_i      = '0;
      wstrb_i      = '0;
      be_rdata_i   = '0;
      be_rvalid_i  = 1'b0;
      be_ready_i   = 1'b0;
      invalidate_i = 1'b0;
      wbuf_empty_i = 1'b1;
      bus_hold     = 1'b0;
      holding      = 1'b0;
      foreach (golden[a]) begin
         golden[a]  = init_word(a);
         bus_mem[a] = init_word(a);
      end
      foreach (line_valid[i]) line_valid[i] = 1'b0;
      build_table();
      cycle_limit = ops.size() * 40 + 100;
      repeat (2) @(negedge clk_i);
      reset_i = 1'b0;
      foreach (ops[i]) run_op(ops[i]);
      // every store reached memory in program order
      foreach (golden[a]) check_value(bus_mem[a], golden[a], "memory contents");
      check_value(data_t'(wbuf_empty_o), 32'd1, "wbuf_empty_o after drain");
      if (u_cache_top.u_checker.fail_cnt != 0) begin
         $display("protocol checker saw %0d assertion failures", u_cache_top.u_checker.fail_cnt);
         $display("Simulation finished: FAIL");
         $fatal(1, "assertion failures");
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire
